// ==== logic/holo_defs.svh ====
// all timing in fpga_clk cycles; fifo depth must equal 2**pointer width, kept in step by hand
`ifndef HOLO_DEFS_SVH
`define HOLO_DEFS_SVH

//////////////////////////////////////////////////
// uart bit timing
//////////////////////////////////////////////////
// clocks per uart bit, scaled down here
// the board ran 868, ie 115200 baud off 100 MHz
`define HOLO_CLKS_PER_BIT 16

// fpga_clk cycles per half period of sck
`define HOLO_SPI_HALF_PERIOD 2

// response queue size and its pointer width
`define HOLO_RESP_FIFO_DEPTH 4
`define HOLO_RESP_PTR_W 2

`endif

// ==== logic/uart_pkg.sv ====
// uart types for 8N1 framing only; no parity or break support anywhere in the design
package uart_pkg;

  // one serial byte
  typedef logic [7:0] uart_byte_t;
  // data bit index, lsb goes first
  typedef logic [2:0] uart_bit_cnt_t;

  // receiver fsm
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_e;

  // transmitter fsm
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_e;

endpackage

// ==== logic/spi_pkg.sv ====
// spi types for a fixed 16-bit frame, address in the upper byte and data in the lower byte
package spi_pkg;

  // full command word, {addr, data}
  typedef logic [15:0] spi_cmd_t;
  // byte the driver returns in the lower half
  typedef logic [7:0] spi_resp_t;
  // bit index over the 16-bit frame
  typedef logic [3:0] spi_bit_cnt_t;

  // master fsm
  // done is a single cycle before idle
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_e;

  // last bit index of a frame
  localparam spi_bit_cnt_t SPI_LAST_BIT = 4'd15;

endpackage

// ==== logic/uart_rx.sv ====
// 8N1 only with no framing error report; start pulses shorter than half a bit are ignored
`include "holo_defs.svh"

module uart_rx import uart_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       rx_serial_i,
  output uart_byte_t rx_byte_o,
  output logic       rx_valid_o
);

  localparam int CLKS_PER_BIT = `HOLO_CLKS_PER_BIT;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);

  uart_rx_state_e   state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  uart_bit_cnt_t    bit_idx_q;
  uart_byte_t       byte_q;
  logic             valid_q;
  logic             rx_meta_q;
  logic             rx_sync_q;
  logic             half_bit;
  logic             bit_end;

  //////////////////////////////////////////////////
  // line synchronizer
  //////////////////////////////////////////////////
  // idle line is high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  assign half_bit = (clk_cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1));
  assign bit_end  = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  //////////////////////////////////////////////////
  // receive fsm
  //////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      // strobe lasts one cycle
      valid_q   <= 1'b0;
      clk_cnt_q <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge = possible start bit
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // still low at half a bit, else a glitch
          if (half_bit) begin
            clk_cnt_q <= '0;
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          // counter now lands on bit centres
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          // flag mid stop bit, rest of it passes in idle
          if (bit_end) begin
            valid_q <= 1'b1;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // data bits, lsb first
  always_ff @(posedge fpga_clk) begin
    if (state_q == RX_DATA && bit_end) begin
      byte_q[bit_idx_q] <= rx_sync_q;
    end
  end

  assign rx_byte_o  = byte_q;
  assign rx_valid_o = valid_q;

endmodule

// ==== logic/uart_tx.sv ====
// 8N1 only; tx_start_i is ignored while a byte is in flight, so the caller waits on tx_active_o
`include "holo_defs.svh"

module uart_tx import uart_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       tx_start_i,
  input  uart_byte_t tx_byte_i,
  output logic       tx_active_o,
  output logic       tx_serial_o
);

  localparam int CLKS_PER_BIT = `HOLO_CLKS_PER_BIT;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);

  uart_tx_state_e   state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  uart_bit_cnt_t    bit_idx_q;
  uart_byte_t       byte_q;
  logic             serial_q;
  logic             bit_end;

  assign bit_end = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  //////////////////////////////////////////////////
  // transmit fsm
  //////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      serial_q  <= 1'b1;
    end else begin
      clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          serial_q  <= 1'b1;
          // start bit goes out right away
          if (tx_start_i) begin
            serial_q <= 1'b0;
            state_q  <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            serial_q <= byte_q[0];
            state_q  <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              serial_q <= 1'b1;
              state_q  <= TX_STOP;
            end else begin
              serial_q <= byte_q[bit_idx_q + 1'b1];
            end
          end
        end
        // active drops at the end of the stop bit
        TX_STOP: begin
          if (bit_end) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // byte held for the whole frame
  always_ff @(posedge fpga_clk) begin
    if (state_q == TX_IDLE && tx_start_i) begin
      byte_q <= tx_byte_i;
    end
  end

  assign tx_active_o = (state_q != TX_IDLE);
  assign tx_serial_o = serial_q;

endmodule

// ==== logic/spi_cmd_assembler.sv ====
// no framing on the host stream; a lost byte shifts the address/data pairing until reset
module spi_cmd_assembler import uart_pkg::*, spi_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  uart_byte_t rx_byte_i,
  input  logic       rx_valid_i,
  output spi_cmd_t   spi_cmd_o,
  output logic       spi_start_o
);

  spi_cmd_t cmd_q;
  logic     odd_byte_q;
  logic     start_q;

  //////////////////////////////////////////////////
  // byte pairing
  //////////////////////////////////////////////////
  // two-byte chain, addr goes out first on spi
  // odd_byte_q set = first byte of a pair seen
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      cmd_q      <= '0;
      odd_byte_q <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (rx_valid_i) begin
        // old data byte moves up to addr
        cmd_q      <= {cmd_q[7:0], rx_byte_i};
        odd_byte_q <= ~odd_byte_q;
        // second byte of the pair, launch
        if (odd_byte_q) begin
          start_q <= 1'b1;
        end
      end
    end
  end

  // cmd and start update on the same edge
  assign spi_cmd_o   = cmd_q;
  assign spi_start_o = start_q;

endmodule

// ==== logic/spi_master.sv ====
// mode 0, fixed 16-bit frame, msb first; sout is sampled without a synchronizer
`include "holo_defs.svh"

module spi_master import spi_pkg::*; (
  input  logic      fpga_clk,
  input  logic      reset_all_cmd_w,
  input  logic      spi_start_i,
  input  spi_cmd_t  spi_cmd_i,
  output logic      spi_busy_o,
  output spi_resp_t spi_resp_o,
  output logic      spi_sen_o,
  output logic      spi_sck_o,
  output logic      spi_sdat_o,
  input  logic      spi_sout_i
);

  localparam int HALF_PERIOD = `HOLO_SPI_HALF_PERIOD;
  localparam int HALF_W      = $clog2(HALF_PERIOD + 1);

  spi_state_e        state_q;
  logic [HALF_W-1:0] half_cnt_q;
  spi_bit_cnt_t      bit_cnt_q;
  spi_cmd_t          shift_q;
  spi_resp_t         resp_q;
  logic              busy_q;
  logic              sen_q;
  logic              sck_q;
  logic              half_end;
  logic              sck_rise;
  logic              sck_fall;

  // sck flips each time a half period runs out
  assign half_end = (state_q == SPI_SHIFT) && (half_cnt_q == HALF_W'(HALF_PERIOD - 1));
  assign sck_rise = half_end && !sck_q;
  assign sck_fall = half_end && sck_q;

  //////////////////////////////////////////////////
  // transfer fsm
  //////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= SPI_IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      shift_q    <= '0;
      busy_q     <= 1'b0;
      sen_q      <= 1'b1;
      sck_q      <= 1'b0;
    end else begin
      case (state_q)
        SPI_IDLE: begin
          half_cnt_q <= '0;
          bit_cnt_q  <= '0;
          // a start seen outside idle is dropped
          if (spi_start_i) begin
            shift_q <= spi_cmd_i;
            busy_q  <= 1'b1;
            sen_q   <= 1'b0;
            state_q <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          half_cnt_q <= half_end ? '0 : half_cnt_q + 1'b1;
          if (half_end) begin
            sck_q <= ~sck_q;
          end
          // next bit out on the falling edge
          if (sck_fall) begin
            if (bit_cnt_q == SPI_LAST_BIT) begin
              state_q <= SPI_DONE;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              shift_q   <= {shift_q[14:0], 1'b0};
            end
          end
        end
        // one trailing cycle, then release sen
        SPI_DONE: begin
          busy_q  <= 1'b0;
          sen_q   <= 1'b1;
          state_q <= SPI_IDLE;
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // sample on rising sck
  // after 16 bits only the lower half is left
  always_ff @(posedge fpga_clk) begin
    if (sck_rise) begin
      resp_q <= {resp_q[6:0], spi_sout_i};
    end
  end

  assign spi_busy_o = busy_q;
  assign spi_resp_o = resp_q;
  assign spi_sen_o  = sen_q;
  assign spi_sck_o  = sck_q;
  assign spi_sdat_o = shift_q[15];

endmodule

// ==== logic/spi_resp_fifo.sv ====
// a response that arrives while the queue is full is dropped without notice
`include "holo_defs.svh"

module spi_resp_fifo import uart_pkg::*, spi_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       spi_busy_i,
  input  spi_resp_t  spi_resp_i,
  input  logic       tx_active_i,
  output uart_byte_t tx_byte_o,
  output logic       tx_start_o
);

  localparam int DEPTH = `HOLO_RESP_FIFO_DEPTH;
  localparam int PTR_W = `HOLO_RESP_PTR_W;
  localparam int CNT_W = PTR_W + 1;

  uart_byte_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             busy_d_q;
  logic             wr_req_q;
  logic             pop_q;
  logic             start_q;
  uart_byte_t       tx_byte_q;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             pop_req;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty   = (count_q == '0);
  assign wr_en   = wr_req_q && !full;
  // uart idle and no pop already on its way
  assign pop_req = !empty && !tx_active_i && !pop_q && !start_q;

  //////////////////////////////////////////////////
  // write and pop sequencing
  //////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      busy_d_q <= 1'b0;
      wr_req_q <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      pop_q    <= 1'b0;
      start_q  <= 1'b0;
    end else begin
      // busy falling = response byte settled
      busy_d_q <= spi_busy_i;
      wr_req_q <= busy_d_q && !spi_busy_i;
      pop_q    <= pop_req;
      // head is registered in the pop cycle
      start_q  <= pop_q;
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_q) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, pop_q})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage and output byte
  always_ff @(posedge fpga_clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= spi_resp_i;
    end
    if (pop_q) begin
      tx_byte_q <= mem_q[rd_ptr_q];
    end
  end

  assign tx_byte_o  = tx_byte_q;
  assign tx_start_o = start_q;

endmodule

// ==== logic/holo_cmd_top.sv ====
// single fpga_clk domain; uart_rx_i is asynchronous and synchronized inside the receiver
module holo_cmd_top import uart_pkg::*, spi_pkg::*; (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  input  logic spi_sout_i
);

  //////////////////////////////////////////////////
  // internal nets
  //////////////////////////////////////////////////
  // host byte in
  uart_byte_t rx_byte;
  logic       rx_valid;
  // assembled command
  spi_cmd_t   spi_cmd;
  logic       spi_start;
  // transfer status and reply
  logic       spi_busy;
  spi_resp_t  spi_resp;
  // reply back to host
  uart_byte_t tx_byte;
  logic       tx_start;
  logic       tx_active;

  uart_rx i_uart_rx (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .rx_serial_i    (uart_rx_i),
    .rx_byte_o      (rx_byte),
    .rx_valid_o     (rx_valid)
  );

  // every second byte fires a transfer
  spi_cmd_assembler i_spi_cmd_assembler (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .rx_byte_i      (rx_byte),
    .rx_valid_i     (rx_valid),
    .spi_cmd_o      (spi_cmd),
    .spi_start_o    (spi_start)
  );

  spi_master i_spi_master (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .spi_start_i    (spi_start),
    .spi_cmd_i      (spi_cmd),
    .spi_busy_o     (spi_busy),
    .spi_resp_o     (spi_resp),
    .spi_sen_o      (spi_sen_o),
    .spi_sck_o      (spi_sck_o),
    .spi_sdat_o     (spi_sdat_o),
    .spi_sout_i     (spi_sout_i)
  );

  // replies queue here while the uart is busy
  spi_resp_fifo i_spi_resp_fifo (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .spi_busy_i     (spi_busy),
    .spi_resp_i     (spi_resp),
    .tx_active_i    (tx_active),
    .tx_byte_o      (tx_byte),
    .tx_start_o     (tx_start)
  );

  uart_tx i_uart_tx (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .tx_start_i     (tx_start),
    .tx_byte_i      (tx_byte),
    .tx_active_o    (tx_active),
    .tx_serial_o    (uart_tx_o)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
// free-running clock from time zero; the reset output is only the power-on pulse
module tb_clock_gen (
  output logic fpga_clk,
  output logic por_reset_o
);

  // period of 4
  initial begin
    fpga_clk = 1'b0;
    forever begin
      #2 fpga_clk = ~fpga_clk;
    end
  end

  // held over two rising edges, released on a falling edge
  initial begin
    por_reset_o = 1'b1;
    repeat (2) @(posedge fpga_clk);
    @(negedge fpga_clk);
    por_reset_o = 1'b0;
  end

endmodule

// ==== dv/spi_master_asserts.sv ====
// watches spi_master pins and its fsm state; rules hold only outside reset
module spi_master_asserts import spi_pkg::*; (
  input logic       fpga_clk,
  input logic       reset_all_cmd_w,
  input logic       spi_start_i,
  input logic       spi_busy_i,
  input logic       spi_sen_i,
  input logic       spi_sck_i,
  input spi_state_e state_i
);

  //////////////////////////////////////////////////
  // frame rules
  //////////////////////////////////////////////////
  // sen is the inverse of busy, cycle by cycle
  sen_tracks_busy: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    spi_sen_i == !spi_busy_i)
    else $error("spi sen does not mirror busy");

  // mode 0, sck parked low outside a frame
  sck_low_when_idle: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    spi_sen_i |-> !spi_sck_i)
    else $error("spi sck high while sen is high");

  // a start mid-frame must not cut the frame
  start_while_busy: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    (spi_start_i && state_i == SPI_SHIFT) |=> !spi_sen_i)
    else $error("spi start during a frame released sen");

endmodule

bind spi_master spi_master_asserts i_spi_master_asserts (
  .fpga_clk       (fpga_clk),
  .reset_all_cmd_w(reset_all_cmd_w),
  .spi_start_i    (spi_start_i),
  .spi_busy_i     (spi_busy_o),
  .spi_sen_i      (spi_sen_o),
  .spi_sck_i      (spi_sck_o),
  .state_i        (state_q)
);

// ==== dv/holo_cmd_tb.sv ====
// drives inputs on falling fpga_clk; slave model answers each frame with the inverted address
`include "holo_defs.svh"

module holo_cmd_tb;

  localparam int CLKS          = `HOLO_CLKS_PER_BIT;
  localparam int START_TIMEOUT = 64 * CLKS;
  localparam int DRAIN_TIMEOUT = 100 * CLKS;

  logic fpga_clk;
  logic por_reset;
  logic soft_reset = 1'b0;
  logic reset_all_cmd_w;
  logic uart_rx    = 1'b1;
  logic uart_tx;
  logic spi_sen;
  logic spi_sck;
  logic spi_sdat;
  logic spi_sout   = 1'b0;

  // expected frames and reply bytes, oldest first
  logic [15:0] exp_cmd_q[$];
  logic [7:0]  exp_resp_q[$];
  logic [31:0] lcg_state = 32'd27707;
  int value_errs   = 0;
  int proto_errs   = 0;
  int timeout_errs = 0;
  int pairs_sent   = 0;
  int frames_seen  = 0;

  // slave model state
  logic [15:0] frame_bits  = '0;
  logic [7:0]  addr_seen   = '0;
  logic        sen_prev    = 1'b1;
  logic        sck_prev    = 1'b0;
  int          rise_cnt    = 0;
  int          fall_cnt    = 0;

  assign reset_all_cmd_w = por_reset | soft_reset;

  tb_clock_gen i_clock_gen (
    .fpga_clk   (fpga_clk),
    .por_reset_o(por_reset)
  );

  holo_cmd_top i_dut (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .uart_rx_i      (uart_rx),
    .uart_tx_o      (uart_tx),
    .spi_sen_o      (spi_sen),
    .spi_sck_o      (spi_sck),
    .spi_sdat_o     (spi_sdat),
    .spi_sout_i     (spi_sout)
  );

  //////////////////////////////////////////////////
  // reference and random source
  //////////////////////////////////////////////////
  // the driver answers with the inverted address
  function automatic logic [7:0] expected_resp(input logic [7:0] addr);
    return ~addr;
  endfunction

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    lcg_state = lcg_step(lcg_state);
    b = lcg_state[23:16];
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////
  // 8N1, lsb first, full stop bit
  task automatic send_byte(input logic [7:0] b);
    int i;
    @(negedge fpga_clk);
    uart_rx = 1'b0;
    repeat (CLKS) @(negedge fpga_clk);
    for (i = 0; i < 8; i++) begin
      uart_rx = b[i];
      repeat (CLKS) @(negedge fpga_clk);
    end
    uart_rx = 1'b1;
    repeat (CLKS) @(negedge fpga_clk);
  endtask

  task automatic send_pair(input logic [7:0] addr, input logic [7:0] data);
    exp_cmd_q.push_back({addr, data});
    exp_resp_q.push_back(expected_resp(addr));
    pairs_sent++;
    send_byte(addr);
    send_byte(data);
  endtask

  task automatic pulse_reset();
    @(negedge fpga_clk);
    soft_reset = 1'b1;
    repeat (2) @(negedge fpga_clk);
    soft_reset = 1'b0;
  endtask

  // lines parked: uart high, sen high, sck low
  task automatic check_idle(input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(negedge fpga_clk);
      assert (uart_tx === 1'b1) else begin
        $display("ERROR uart_tx_o got 0x%0h expected 0x1", uart_tx);
        value_errs++;
      end
      assert (spi_sen === 1'b1) else begin
        $display("ERROR spi_sen_o got 0x%0h expected 0x1", spi_sen);
        value_errs++;
      end
      assert (spi_sck === 1'b0) else begin
        $display("ERROR spi_sck_o got 0x%0h expected 0x0", spi_sck);
        value_errs++;
      end
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while ((exp_cmd_q.size() > 0 || exp_resp_q.size() > 0) && cnt < DRAIN_TIMEOUT) begin
      @(negedge fpga_clk);
      cnt++;
    end
    assert (exp_cmd_q.size() == 0 && exp_resp_q.size() == 0) else begin
      $display("timeout while waiting for spi transfers and uart replies");
      timeout_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // spi slave model
  //////////////////////////////////////////////////
  // sampled on falling fpga_clk, sck and sdat move on rising
  always @(negedge fpga_clk) begin : spi_slave
    logic [15:0] exp_cmd;
    if (spi_sen === 1'b1) begin
      // sen rising closes a frame
      if (!sen_prev) begin
        frames_seen++;
        assert (exp_cmd_q.size() > 0) else begin
          $display("spi transfer seen with no command pending");
          proto_errs++;
        end
        assert (rise_cnt == 16) else begin
          $display("spi frame did not carry 16 sck pulses");
          proto_errs++;
        end
        if (exp_cmd_q.size() > 0) begin
          exp_cmd = exp_cmd_q.pop_front();
          assert (frame_bits == exp_cmd) else begin
            $display("ERROR spi_sdat_o got 0x%04h expected 0x%04h", frame_bits, exp_cmd);
            value_errs++;
          end
        end
      end
      rise_cnt = 0;
      fall_cnt = 0;
      spi_sout <= 1'b0;
    end else begin
      if (spi_sck && !sck_prev) begin
        frame_bits = {frame_bits[14:0], spi_sdat};
        rise_cnt++;
        if (rise_cnt == 8) begin
          addr_seen = frame_bits[7:0];
        end
      end
      if (!spi_sck && sck_prev) begin
        fall_cnt++;
      end
      // lower half carries the inverted address, msb first
      if (fall_cnt >= 8 && fall_cnt < 16) begin
        spi_sout <= ~addr_seen[15 - fall_cnt];
      end else begin
        spi_sout <= 1'b0;
      end
    end
    sen_prev = spi_sen;
    sck_prev = spi_sck;
  end

  //////////////////////////////////////////////////
  // uart decoder and reply checker
  //////////////////////////////////////////////////
  // status 0 ok, 1 no start bit, 2 short start, 3 bad stop
  task automatic decode_uart_byte(output logic [7:0] b, output int status);
    int cnt;
    int i;
    b = '0;
    status = 0;
    cnt = 0;
    while (uart_tx === 1'b1 && cnt < START_TIMEOUT) begin
      @(negedge fpga_clk);
      cnt++;
    end
    if (uart_tx === 1'b1) begin
      status = 1;
      return;
    end
    repeat (CLKS / 2) @(negedge fpga_clk);
    if (uart_tx !== 1'b0) begin
      status = 2;
      return;
    end
    for (i = 0; i < 8; i++) begin
      repeat (CLKS) @(negedge fpga_clk);
      b[i] = uart_tx;
    end
    repeat (CLKS) @(negedge fpga_clk);
    if (uart_tx !== 1'b1) begin
      status = 3;
    end
  endtask

  initial begin : compare_resp
    logic [7:0] got;
    logic [7:0] exp_byte;
    int status;
    forever begin
      @(negedge fpga_clk);
      if (exp_resp_q.size() > 0) begin
        decode_uart_byte(got, status);
        exp_byte = exp_resp_q.pop_front();
        assert (status != 1) else begin
          $display("timeout waiting for a start bit on uart_tx_o");
          timeout_errs++;
        end
        assert (status != 2 && status != 3) else begin
          $display("framing error on uart_tx_o, bad start or stop bit");
          proto_errs++;
        end
        assert (status != 0 || got == exp_byte) else begin
          $display("ERROR uart_tx_o got 0x%02h expected 0x%02h", got, exp_byte);
          value_errs++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin : stimulus
    logic [7:0] addr;
    logic [7:0] data;
    int cnt;
    int i;
    cnt = 0;
    while (reset_all_cmd_w !== 1'b0 && cnt < 100) begin
      @(negedge fpga_clk);
      cnt++;
    end
    assert (reset_all_cmd_w === 1'b0) else begin
      $display("power-on reset was never released");
      timeout_errs++;
    end

    // quiet lines with no input
    check_idle(200);

    // lone byte, no frame expected
    send_byte(8'h5a);
    check_idle(100);

    // reset mid pair, next two bytes pair up fresh
    pulse_reset();
    check_idle(20);
    send_pair(8'hc3, 8'h3c);
    wait_drain();

    // random pairs, no gap between bytes
    for (i = 0; i < 8; i++) begin
      rand_byte(addr);
      rand_byte(data);
      send_pair(addr, data);
    end
    wait_drain();

    assert (frames_seen == pairs_sent) else begin
      $display("spi transfer count %0d differs from pair count %0d", frames_seen, pairs_sent);
      proto_errs++;
    end

    $display("errors: value %0d, protocol %0d, timeout %0d",
             value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== holo_cmd_top.f ====
+incdir+logic
logic/uart_pkg.sv
logic/spi_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/spi_cmd_assembler.sv
logic/spi_master.sv
logic/spi_resp_fifo.sv
logic/holo_cmd_top.sv
dv/tb_clock_gen.sv
dv/spi_master_asserts.sv
dv/holo_cmd_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module holo_cmd_tb -Mdir obj_dir -f holo_cmd_top.f \
  && ./obj_dir/Vholo_cmd_tb | tee /dev/stderr | grep -qx "ALL TESTS PASSED" \
  && { echo "simulation result: pass"; exit 0; } \
  || { echo "simulation result: fail"; exit 1; }
